//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_rv32i_core
FILELIST  ?= sim.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- rv32i_basereg.sv
`timescale 1ns/10ps
`default_nettype none

module rv32i_basereg import rv32i_pkg::*; (
    input  logic      i_clk,
    input  reg_addr_t i_rs1_addr,               // read port 1
    input  reg_addr_t i_rs2_addr,               // read port 2
    input  logic      i_wr,                     // write enable
    input  reg_addr_t i_rd_addr,
    input  word_t     i_rd,                     // write data
    output word_t     o_rs1,
    output word_t     o_rs2
);

    word_t regs [1:31];                         // x0 is not stored

    // write port, x0 writes dropped
    always_ff @(posedge i_clk) begin
        if (i_wr && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd;
        end
    end

    // async reads, old value on same-cycle write
    assign o_rs1 = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2 = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

//--- rv32i_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv32i_core import rv32i_pkg::*; #(
    parameter word_t pc_reset = 32'h0000_0000
) (
    input  logic      i_clk,
    input  logic      i_rst,

    // instruction memory
    output word_t     o_iaddr,                  // request address
    output logic      o_imem_req,               // one cycle strobe
    input  logic      i_ack_inst,               // instruction ready
    input  word_t     i_inst,

    // retire trace
    output logic      o_retire_valid,
    output word_t     o_retire_pc,
    output logic      o_retire_wr,
    output reg_addr_t o_retire_rd_addr,
    output word_t     o_retire_rd_data
);

    // fetch -> decode
    logic      inst_valid;
    word_t     inst;
    word_t     inst_pc;

    // execute -> fetch, decode
    logic      redirect;
    word_t     redirect_pc;

    // register file read side
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1;
    word_t     rs2;

    rv32i_stage_if stage ();                    // decode -> execute

    //////////////////////////////////////////////////
    // stage 1, fetch
    //////////////////////////////////////////////////
    rv32i_fetch #(.pc_reset(pc_reset)) u_fetch (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .o_iaddr       (o_iaddr),
        .o_imem_req    (o_imem_req),
        .i_ack_inst    (i_ack_inst),
        .i_inst        (i_inst),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_inst_valid  (inst_valid),
        .o_inst        (inst),
        .o_inst_pc     (inst_pc)
    );

    //////////////////////////////////////////////////
    // stage 2, decode
    //////////////////////////////////////////////////
    rv32i_decode u_decode (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_inst_valid (inst_valid),
        .i_inst       (inst),
        .i_inst_pc    (inst_pc),
        .i_redirect   (redirect),
        .stage        (stage.decode_mp),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr)
    );

    rv32i_basereg u_basereg (
        .i_clk      (i_clk),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_wr       (o_retire_wr),              // retire reg is the write port
        .i_rd_addr  (o_retire_rd_addr),
        .i_rd       (o_retire_rd_data),
        .o_rs1      (rs1),
        .o_rs2      (rs2)
    );

    //////////////////////////////////////////////////
    // stage 3, execute and retire
    //////////////////////////////////////////////////
    rv32i_execute u_execute (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .stage            (stage.execute_mp),
        .i_rs1            (rs1),
        .i_rs2            (rs2),
        .o_redirect       (redirect),
        .o_redirect_pc    (redirect_pc),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_wr      (o_retire_wr),
        .o_retire_rd_addr (o_retire_rd_addr),
        .o_retire_rd_data (o_retire_rd_data)
    );

endmodule

`default_nettype wire

//--- rv32i_core_props.sv
`timescale 1ns/10ps
`default_nettype none

module rv32i_core_props import rv32i_pkg::*; (
    input wire logic      i_clk,
    input wire logic      i_rst,
    input wire logic      o_imem_req,
    input wire logic      i_ack_inst,
    input wire logic      o_retire_valid,
    input wire logic      o_retire_wr,
    input wire reg_addr_t o_retire_rd_addr
);

    logic pending_q;                            // request sent and not yet acked

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pending_q <= 1'b0;
        end else if (o_imem_req) begin
            pending_q <= 1'b1;
        end else if (i_ack_inst) begin
            pending_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // handshake and retire rules
    //////////////////////////////////////////////////
    quiet_in_reset: assert property (@(posedge i_clk)
        $past(i_rst) |-> (!o_imem_req && !o_retire_valid))
        else $error("request or retire active during reset");

    one_outstanding: assert property (@(posedge i_clk) disable iff (i_rst)
        ((o_imem_req || pending_q) && !i_ack_inst) |=> !o_imem_req)
        else $error("new request before acknowledge");

    no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
        o_retire_wr |-> (o_retire_rd_addr != '0))
        else $error("retire write names x0");

endmodule

bind rv32i_core rv32i_core_props u_props (.*);

`default_nettype wire

//--- rv32i_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv32i_decode import rv32i_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_inst_valid,             // from fetch, same edge load
    input  word_t     i_inst,
    input  word_t     i_inst_pc,
    input  logic      i_redirect,               // flush this slot
    rv32i_stage_if.decode_mp stage,
    output reg_addr_t o_rs1_addr,               // register file read ports
    output reg_addr_t o_rs2_addr
);

    word_t      inst_q;
    word_t      pc_q;
    logic       valid_q;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;                      // sub / sra select

    //////////////////////////////////////////////////
    // decode stage register
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_inst_valid && !i_redirect;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_inst_valid) begin
            inst_q <= i_inst;
            pc_q   <= i_inst_pc;
        end
    end

    // fields
    assign opcode    = inst_q[6:0];
    assign funct3    = inst_q[14:12];
    assign funct7_b5 = inst_q[30];

    assign o_rs1_addr     = inst_q[19:15];
    assign o_rs2_addr     = inst_q[24:20];
    assign stage.rs1_addr = inst_q[19:15];      // for forwarding compare
    assign stage.rs2_addr = inst_q[24:20];
    assign stage.rd_addr  = inst_q[11:7];
    assign stage.funct3   = funct3;
    assign stage.pc       = pc_q;
    assign stage.valid    = valid_q;

    //////////////////////////////////////////////////
    // class, immediate and alu op
    //////////////////////////////////////////////////
    always_comb begin
        stage.op_class = cls_illegal;
        stage.use_imm  = 1'b0;
        stage.imm      = {{20{inst_q[31]}}, inst_q[31:20]};   // i-type
        case (opcode)
            opc_op:     stage.op_class = cls_op;
            opc_op_imm: begin
                stage.op_class = cls_op_imm;
                stage.use_imm  = 1'b1;
            end
            opc_lui: begin
                stage.op_class = cls_lui;
                stage.imm      = {inst_q[31:12], 12'b0};       // u-type
            end
            opc_auipc: begin
                stage.op_class = cls_auipc;
                stage.imm      = {inst_q[31:12], 12'b0};
            end
            opc_jal: begin
                stage.op_class = cls_jal;
                stage.imm      = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12],
                                  inst_q[20], inst_q[30:21], 1'b0};   // j-type
            end
            opc_jalr: begin
                stage.op_class = cls_jalr;
                stage.use_imm  = 1'b1;          // target is rs1 + imm
            end
            opc_branch: begin
                stage.imm = {{19{inst_q[31]}}, inst_q[31], inst_q[7],
                             inst_q[30:25], inst_q[11:8], 1'b0};      // b-type
                case (funct3)
                    f3_beq, f3_bne, f3_blt,
                    f3_bge, f3_bltu, f3_bgeu: stage.op_class = cls_branch;
                    default:                  stage.op_class = cls_illegal;
                endcase
            end
            default: stage.op_class = cls_illegal;
        endcase
    end

    always_comb begin
        stage.alu_op = alu_add;                 // jalr and the rest add
        if (opcode == opc_op || opcode == opc_op_imm) begin
            case (funct3)
                3'b000: stage.alu_op = (opcode == opc_op && funct7_b5) ? alu_sub : alu_add;
                3'b001: stage.alu_op = alu_sll;
                3'b010: stage.alu_op = alu_slt;
                3'b011: stage.alu_op = alu_sltu;
                3'b100: stage.alu_op = alu_xor;
                3'b101: stage.alu_op = funct7_b5 ? alu_sra : alu_srl;
                3'b110: stage.alu_op = alu_or;
                default: stage.alu_op = alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rv32i_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv32i_execute import rv32i_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    rv32i_stage_if.execute_mp stage,
    input  word_t     i_rs1,                    // register file values
    input  word_t     i_rs2,
    output logic      o_redirect,               // one cycle, flushes younger
    output word_t     o_redirect_pc,
    output logic      o_retire_valid,
    output word_t     o_retire_pc,
    output logic      o_retire_wr,              // also register file write
    output reg_addr_t o_retire_rd_addr,
    output word_t     o_retire_rd_data
);

    word_t     rs1_fwd;
    word_t     rs2_fwd;
    word_t     alu_b;
    word_t     alu_y;
    word_t     pc_imm;                          // auipc, jal and branch target
    word_t     link;
    word_t     result;
    logic      branch_cond;
    logic      taken;
    logic      writes_rd;
    logic [4:0] shamt;

    //////////////////////////////////////////////////
    // operand forwarding from retire register
    //////////////////////////////////////////////////
    assign rs1_fwd = (o_retire_wr && o_retire_rd_addr != '0 &&
                      o_retire_rd_addr == stage.rs1_addr) ? o_retire_rd_data : i_rs1;
    assign rs2_fwd = (o_retire_wr && o_retire_rd_addr != '0 &&
                      o_retire_rd_addr == stage.rs2_addr) ? o_retire_rd_data : i_rs2;

    assign alu_b = stage.use_imm ? stage.imm : rs2_fwd;
    assign shamt = alu_b[4:0];

    // alu
    always_comb begin
        case (stage.alu_op)
            alu_add:  alu_y = rs1_fwd + alu_b;
            alu_sub:  alu_y = rs1_fwd - alu_b;
            alu_sll:  alu_y = rs1_fwd << shamt;
            alu_slt:  alu_y = {{(xlen-1){1'b0}}, $signed(rs1_fwd) < $signed(alu_b)};
            alu_sltu: alu_y = {{(xlen-1){1'b0}}, rs1_fwd < alu_b};
            alu_xor:  alu_y = rs1_fwd ^ alu_b;
            alu_srl:  alu_y = rs1_fwd >> shamt;
            alu_sra:  alu_y = word_t'($signed(rs1_fwd) >>> shamt);
            alu_or:   alu_y = rs1_fwd | alu_b;
            alu_and:  alu_y = rs1_fwd & alu_b;
            default:  alu_y = '0;
        endcase
    end

    assign pc_imm = stage.pc + stage.imm;
    assign link   = stage.pc + 32'd4;

    //////////////////////////////////////////////////
    // branch resolution and redirect
    //////////////////////////////////////////////////
    always_comb begin
        case (stage.funct3)
            f3_beq:  branch_cond = (rs1_fwd == rs2_fwd);
            f3_bne:  branch_cond = (rs1_fwd != rs2_fwd);
            f3_blt:  branch_cond = ($signed(rs1_fwd) < $signed(rs2_fwd));
            f3_bge:  branch_cond = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            f3_bltu: branch_cond = (rs1_fwd < rs2_fwd);
            f3_bgeu: branch_cond = (rs1_fwd >= rs2_fwd);
            default: branch_cond = 1'b0;
        endcase
    end

    assign taken = stage.valid && (stage.op_class == cls_jal || stage.op_class == cls_jalr ||
                                   (stage.op_class == cls_branch && branch_cond));

    assign o_redirect    = taken;
    assign o_redirect_pc = (stage.op_class == cls_jalr) ? {alu_y[xlen-1:1], 1'b0} : pc_imm;

    // result select
    always_comb begin
        case (stage.op_class)
            cls_lui:           result = stage.imm;
            cls_auipc:         result = pc_imm;
            cls_jal, cls_jalr: result = link;
            default:           result = alu_y;      // op, op_imm
        endcase
    end

    // no write for x0, branches or illegal
    assign writes_rd = stage.valid && stage.rd_addr != '0 &&
                       stage.op_class != cls_branch && stage.op_class != cls_illegal;

    //////////////////////////////////////////////////
    // retire register
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_retire_valid <= 1'b0;
            o_retire_wr    <= 1'b0;
        end else begin
            o_retire_valid <= stage.valid;
            o_retire_wr    <= writes_rd;
        end
    end

    always_ff @(posedge i_clk) begin
        o_retire_pc      <= stage.pc;
        o_retire_rd_addr <= stage.rd_addr;
        o_retire_rd_data <= result;
    end

endmodule

`default_nettype wire

//--- rv32i_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv32i_fetch import rv32i_pkg::*; #(
    parameter word_t pc_reset = 32'h0000_0000
) (
    input  logic  i_clk,
    input  logic  i_rst,
    output word_t o_iaddr,
    output logic  o_imem_req,
    input  logic  i_ack_inst,
    input  word_t i_inst,
    input  logic  i_redirect,                   // taken branch or jump in execute
    input  word_t i_redirect_pc,
    output logic  o_inst_valid,                 // load decode register
    output word_t o_inst,
    output word_t o_inst_pc
);

    word_t pc_q;                                // address of current request
    logic  req_q;                               // request strobe
    logic  outstanding_q;                       // waiting for ack
    logic  discard_q;                           // ack belongs to a flushed path
    logic  accept;

    // a redirect in the ack cycle kills that instruction too
    assign accept = i_ack_inst && !discard_q && !i_redirect;

    assign o_iaddr      = pc_q;
    assign o_imem_req   = req_q;
    assign o_inst_valid = accept;
    assign o_inst       = i_inst;
    assign o_inst_pc    = pc_q;                 // pc_q only moves on ack

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q          <= pc_reset;
            req_q         <= 1'b0;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
        end else begin
            // first request out of reset, then one per ack
            req_q <= (!req_q && !outstanding_q) || i_ack_inst;

            if (req_q) begin
                outstanding_q <= 1'b1;
            end else if (i_ack_inst) begin
                outstanding_q <= 1'b0;
            end

            if (i_redirect) begin
                pc_q      <= i_redirect_pc;     // next request goes to target
                discard_q <= (req_q || outstanding_q) && !i_ack_inst;
            end else if (i_ack_inst) begin
                discard_q <= 1'b0;
                if (!discard_q) begin
                    pc_q <= pc_q + 32'd4;       // sequential
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    //////////////////////////////////////////////////
    // widths and base types
    //////////////////////////////////////////////////
    localparam int xlen = 32;                   // data, address and pc width

    typedef logic [4:0]      reg_addr_t;        // x0..x31
    typedef logic [xlen-1:0] word_t;            // one register or pc value

    //////////////////////////////////////////////////
    // major opcodes, inst[6:0]
    //////////////////////////////////////////////////
    localparam logic [6:0] opc_op     = 7'b0110011; // reg-reg alu
    localparam logic [6:0] opc_op_imm = 7'b0010011; // reg-imm alu
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // branch conditions in funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    //////////////////////////////////////////////////
    // decoded operation types
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,                        // signed compare
        alu_sltu = 4'd4,                        // unsigned compare
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,                        // keeps sign bit
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    typedef enum logic [2:0] {
        cls_op      = 3'd0,
        cls_op_imm  = 3'd1,
        cls_lui     = 3'd2,
        cls_auipc   = 3'd3,
        cls_jal     = 3'd4,
        cls_jalr    = 3'd5,
        cls_branch  = 3'd6,
        cls_illegal = 3'd7                      // retires, no write
    } op_class_t;

endpackage

`default_nettype wire

//--- rv32i_stage_if.sv
`timescale 1ns/10ps
`default_nettype none

// decoded instruction, decode register -> execute
interface rv32i_stage_if import rv32i_pkg::*; ();

    logic      valid;                           // slot holds a live instruction
    op_class_t op_class;
    alu_op_t   alu_op;
    logic [2:0] funct3;                         // branch condition
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     imm;                             // sign extended immediate
    word_t     pc;
    logic      use_imm;                         // alu b operand is imm

    modport decode_mp (
        output valid, op_class, alu_op, funct3,
        output rs1_addr, rs2_addr, rd_addr,
        output imm, pc, use_imm
    );

    modport execute_mp (
        input valid, op_class, alu_op, funct3,
        input rs1_addr, rs2_addr, rd_addr,
        input imm, pc, use_imm
    );

endinterface

`default_nettype wire

//--- sim.f
rv32i_pkg.sv
rv32i_stage_if.sv
rv32i_fetch.sv
rv32i_decode.sv
rv32i_basereg.sv
rv32i_execute.sv
rv32i_core.sv
rv32i_core_props.sv
tb_rv32i_core.sv

//--- tb_rv32i_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv32i_core import rv32i_pkg::*; ();

    localparam word_t pc_start = 32'h0000_1000;  // nonzero aligned reset pc
    localparam int    clk_half = 20;             // 40 ns period
    localparam int    drv_dly  = 2;              // input skew after posedge
    localparam int    prog_len = 29;
    localparam int    max_exp  = 32;

    logic      i_clk;
    logic      i_rst;
    logic      i_ack_inst;
    word_t     i_inst;
    word_t     o_iaddr;
    logic      o_imem_req;
    logic      o_retire_valid;
    word_t     o_retire_pc;
    logic      o_retire_wr;
    reg_addr_t o_retire_rd_addr;
    word_t     o_retire_rd_data;

    word_t     prog [0:prog_len-1];              // instruction words from pc_start
    string     exp_name [0:max_exp-1];
    word_t     exp_pc   [0:max_exp-1];
    logic      exp_wr   [0:max_exp-1];
    reg_addr_t exp_rd   [0:max_exp-1];
    word_t     exp_data [0:max_exp-1];
    int        n_exp;
    int        ret_idx;                          // next expected retire
    int        error_count;
    int        check_count;
    int        seed;
    logic      first_req;

    rv32i_core #(.pc_reset(pc_start)) DUT (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .o_iaddr          (o_iaddr),
        .o_imem_req       (o_imem_req),
        .i_ack_inst       (i_ack_inst),
        .i_inst           (i_inst),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_wr      (o_retire_wr),
        .o_retire_rd_addr (o_retire_rd_addr),
        .o_retire_rd_data (o_retire_rd_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #clk_half i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // checks and tables
    //////////////////////////////////////////////////
    task automatic check_value(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_expect(input string name, input word_t pc, input logic wr,
                              input reg_addr_t rd, input word_t data);
        exp_name[n_exp] = name;
        exp_pc[n_exp]   = pc;
        exp_wr[n_exp]   = wr;
        exp_rd[n_exp]   = rd;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    function automatic word_t fetch_word(input word_t addr);
        int idx;
        idx = int'((addr - pc_start) >> 2);
        if (idx >= 0 && idx < prog_len) begin
            return prog[idx];
        end
        return 32'h0000_0013;                    // nop outside the program
    endfunction

    initial begin
        // hand encoded program
        prog[0]  = 32'h0050_0093;                // addi x1, x0, 5
        prog[1]  = 32'hFFD0_0113;                // addi x2, x0, -3
        prog[2]  = 32'h0020_81B3;                // add  x3, x1, x2
        prog[3]  = 32'h4020_8233;                // sub  x4, x1, x2
        prog[4]  = 32'h0011_22B3;                // slt  x5, x2, x1
        prog[5]  = 32'h0011_3333;                // sltu x6, x2, x1
        prog[6]  = 32'h4011_5393;                // srai x7, x2, 1
        prog[7]  = 32'h0041_5413;                // srli x8, x2, 4
        prog[8]  = 32'h1234_54B7;                // lui  x9, 0x12345
        prog[9]  = 32'h0000_1517;                // auipc x10, 1
        prog[10] = 32'h0015_0513;                // addi x10, x10, 1 back to back
        prog[11] = 32'h0095_45B3;                // xor  x11, x10, x9
        prog[12] = 32'h0070_8013;                // addi x0, x1, 7
        prog[13] = 32'h0010_0633;                // add  x12, x0, x1
        prog[14] = 32'h0010_8663;                // beq  x1, x1, +12 taken
        prog[15] = 32'h0010_0693;                // skipped
        prog[16] = 32'h0020_0693;                // skipped
        prog[17] = 32'h0010_9463;                // bne  x1, x1, +8 falls through
        prog[18] = 32'h0011_4463;                // blt  x2, x1, +8 taken
        prog[19] = 32'h0030_0693;                // skipped
        prog[20] = 32'h0011_6463;                // bltu x2, x1, +8 falls through
        prog[21] = 32'h00C0_076F;                // jal  x14, +12
        prog[22] = 32'h0040_0693;                // skipped
        prog[23] = 32'h0050_0693;                // skipped
        prog[24] = 32'h0047_0793;                // addi x15, x14, 4
        prog[25] = 32'h0117_8867;                // jalr x16, 17(x15)
        prog[26] = 32'h0060_0693;                // skipped
        prog[27] = 32'h00C8_08B3;                // add  x17, x16, x12
        prog[28] = 32'h0000_006F;                // jal x0, 0 spins here

        // retire order and values
        n_exp = 0;
        add_expect("addi_pos",   32'h1000, 1'b1, 5'd1,  32'h0000_0005);
        add_expect("addi_neg",   32'h1004, 1'b1, 5'd2,  32'hFFFF_FFFD);
        add_expect("add",        32'h1008, 1'b1, 5'd3,  32'h0000_0002);
        add_expect("sub",        32'h100C, 1'b1, 5'd4,  32'h0000_0008);
        add_expect("slt",        32'h1010, 1'b1, 5'd5,  32'h0000_0001);
        add_expect("sltu",       32'h1014, 1'b1, 5'd6,  32'h0000_0000);
        add_expect("srai",       32'h1018, 1'b1, 5'd7,  32'hFFFF_FFFE);
        add_expect("srli",       32'h101C, 1'b1, 5'd8,  32'h0FFF_FFFF);
        add_expect("lui",        32'h1020, 1'b1, 5'd9,  32'h1234_5000);
        add_expect("auipc",      32'h1024, 1'b1, 5'd10, 32'h0000_2024);
        add_expect("fwd_addi",   32'h1028, 1'b1, 5'd10, 32'h0000_2025);
        add_expect("fwd_xor",    32'h102C, 1'b1, 5'd11, 32'h1234_7025);
        add_expect("write_x0",   32'h1030, 1'b0, 5'd0,  32'h0);
        add_expect("read_x0",    32'h1034, 1'b1, 5'd12, 32'h0000_0005);
        add_expect("beq_taken",  32'h1038, 1'b0, 5'd0,  32'h0);
        add_expect("bne_fall",   32'h1044, 1'b0, 5'd0,  32'h0);
        add_expect("blt_taken",  32'h1048, 1'b0, 5'd0,  32'h0);
        add_expect("bltu_fall",  32'h1050, 1'b0, 5'd0,  32'h0);
        add_expect("jal_link",   32'h1054, 1'b1, 5'd14, 32'h0000_1058);
        add_expect("use_link",   32'h1060, 1'b1, 5'd15, 32'h0000_105C);
        add_expect("jalr_link",  32'h1064, 1'b1, 5'd16, 32'h0000_1068);
        add_expect("fwd_jalr",   32'h106C, 1'b1, 5'd17, 32'h0000_106D);
        add_expect("spin",       32'h1070, 1'b0, 5'd0,  32'h0);
    end

    //////////////////////////////////////////////////
    // instruction responder with 1 to 3 cycle ack
    //////////////////////////////////////////////////
    initial begin
        word_t req_addr;
        int    delay;
        seed       = 87714;
        first_req  = 1'b1;
        i_ack_inst = 1'b0;
        i_inst     = '0;
        forever begin
            @(negedge i_clk);
            if (o_imem_req && !i_rst) begin
                req_addr = o_iaddr;
                if (first_req) begin
                    check_value("first_request", pc_start, req_addr);
                    first_req = 1'b0;
                end
                delay = 1 + int'($unsigned($random(seed)) % 3);
                repeat (delay) @(posedge i_clk);
                #drv_dly;
                i_ack_inst = 1'b1;
                i_inst     = fetch_word(req_addr);
                @(posedge i_clk);
                #drv_dly;
                i_ack_inst = 1'b0;
            end
        end
    end

    // retire monitor sampled mid cycle
    always @(negedge i_clk) begin
        if (!i_rst && o_retire_valid) begin
            if (ret_idx >= n_exp) begin
                error_count++;
                $display("retire at pc %h after the end of the expected table", o_retire_pc);
            end else begin
                check_value({exp_name[ret_idx], ".pc"}, exp_pc[ret_idx], o_retire_pc);
                check_value({exp_name[ret_idx], ".wr"}, word_t'(exp_wr[ret_idx]),
                            word_t'(o_retire_wr));
                if (exp_wr[ret_idx]) begin
                    check_value({exp_name[ret_idx], ".rd"}, word_t'(exp_rd[ret_idx]),
                                word_t'(o_retire_rd_addr));
                    check_value({exp_name[ret_idx], ".data"}, exp_data[ret_idx],
                                o_retire_rd_data);
                end
            end
            ret_idx++;
        end
    end

    // watchdog allows 10 cycles per expected retire
    initial begin
        #1;
        repeat (n_exp * 10 + 4) @(posedge i_clk);
        $display("timeout: only %0d of %0d instructions retired", ret_idx, n_exp);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        error_count = 0;
        check_count = 0;
        ret_idx     = 0;
        i_rst       = 1'b1;
        repeat (4) @(posedge i_clk);
        #drv_dly;
        i_rst = 1'b0;
        wait (ret_idx >= n_exp);
        @(posedge i_clk);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
